//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_zx_core
FLIST     ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
rtl/zx_bus_pkg.sv
rtl/zx_mem_pkg.sv
rtl/z80_bus_if.sv
rtl/port_state_if.sv
rtl/reset_stretch.sv
rtl/zports.sv
rtl/zmem_map.sv
rtl/zint.sv
rtl/zx_core_top.sv
test/zx_core_props.sv
test/tb_zx_core.sv

//--- rtl/port_state_if.sv
`timescale 1ns/1ns

interface port_state_if;

	logic [zx_bus_pkg::DATA_W-1:0] p7ffd;
	logic [zx_bus_pkg::DATA_W-1:0] peff7;
	logic                          lock;

	modport src (output p7ffd, output peff7, output lock);

	modport dst (input p7ffd, input peff7, input lock);

endinterface

//--- rtl/reset_stretch.sv
`timescale 1ns/1ns

module reset_stretch #(
	parameter int RST_CNT_SIZE = 6
) (
	input  logic fclk,
	input  logic rst_n,
	output logic rst_core_n
);

	logic [1:0]              sync_q;
	logic [RST_CNT_SIZE-1:0] cnt;

	// assert at once, release after sync and count
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync_q     <= '0;
			cnt        <= '0;
			rst_core_n <= 1'b0;
		end
		else
		begin
			sync_q <= {sync_q[0], 1'b1};
			if (sync_q[1] && !rst_core_n)
				cnt <= cnt + 1'b1;
			if (&cnt)
				rst_core_n <= 1'b1;
		end
	end

endmodule

//--- rtl/z80_bus_if.sv
`timescale 1ns/1ns

interface z80_bus_if;

	logic [zx_bus_pkg::ADDR_W-1:0] a;
	logic [zx_bus_pkg::DATA_W-1:0] din;
	logic                          iorq_n;
	logic                          mreq_n;
	logic                          rd_n;
	logic                          wr_n;
	logic                          m1_n;

	modport sink (input a, input din, input iorq_n, input mreq_n,
		input rd_n, input wr_n, input m1_n);

	// int acknowledge only
	modport ack (input iorq_n, input m1_n);

endinterface

//--- rtl/zint.sv
`timescale 1ns/1ns

module zint #(
	parameter int FRAME_CYCLES = 71680,
	parameter int INT_CYCLES   = 32
) (
	input  logic   fclk,
	input  logic   rst_n,
	z80_bus_if.ack bus,
	output logic   int_n
);
	import zx_bus_pkg::*;

	localparam int FRAME_W = $clog2(FRAME_CYCLES);
	localparam int PULSE_W = $clog2(INT_CYCLES);

	logic [FRAME_W-1:0] frame_cnt;
	logic [PULSE_W-1:0] pulse_cnt;
	logic               wrap;
	logic               pulse_end;

	assign wrap      = frame_cnt == FRAME_W'(FRAME_CYCLES - 1);
	assign pulse_end = pulse_cnt == PULSE_W'(INT_CYCLES - 1);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			frame_cnt <= '0;
		else if (wrap)
			frame_cnt <= '0;
		else
			frame_cnt <= frame_cnt + 1'b1;
	end

	// pulse ends on length or on acknowledge
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			int_n     <= 1'b1;
			pulse_cnt <= '0;
		end
		else if (!int_n)
		begin
			pulse_cnt <= pulse_cnt + 1'b1;
			if (pulse_end || ack_cycle(bus.iorq_n, bus.m1_n))
				int_n <= 1'b1;
		end
		else if (wrap)
		begin
			int_n     <= 1'b0;
			pulse_cnt <= '0;
		end
	end

endmodule

//--- rtl/zmem_map.sv
`timescale 1ns/1ns

module zmem_map (
	input  logic                  fclk,
	input  logic                  rst_n,
	z80_bus_if.sink               bus,
	port_state_if.dst             pst,
	output logic                  csrom,
	output logic                  romoe_n,
	output logic                  rompg0_n,
	output logic                  dos_n,
	output logic                  ram_cs,
	output zx_mem_pkg::ram_page_t mem_page
);
	import zx_mem_pkg::*;

	win_idx_t   win;
	rom_bank_t  rom_bank;
	page_word_u pw;
	logic       romnram;
	logic       mem_act;
	logic       m1_rd;
	logic       m1_rd_q;
	logic       m1_stb;
	logic       dos;

	assign win      = bus.a[15:14];
	assign rom_bank = {dos, pst.p7ffd[4]};

	always_comb
	begin
		pw      = '0;
		romnram = 1'b0;
		case (win)
			2'd0:
			begin
				// eff7 bit 2 puts ram page 0 over the rom
				if (!pst.peff7[2])
				begin
					romnram     = 1'b1;
					pw.rom.bank = rom_bank;
				end
			end
			2'd1:
				pw.ram = RAM_PAGE_WIN1;
			2'd2:
				pw.ram = RAM_PAGE_WIN2;
			default:
				pw.ram = ram_page_t'(pst.p7ffd[2:0]);
		endcase
	end

	assign mem_act  = ~bus.mreq_n;
	assign csrom    = mem_act & romnram;
	assign romoe_n  = ~(csrom & ~bus.rd_n);
	assign ram_cs   = mem_act & ~romnram;
	assign mem_page = ram_cs ? pw.ram : '0;
	assign rompg0_n = ~rom_bank[0];

	////////////////////////////////////////
	// dos latch
	////////////////////////////////////////

	assign m1_rd  = ~bus.mreq_n & ~bus.rd_n & ~bus.m1_n;
	assign m1_stb = m1_rd & ~m1_rd_q;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			m1_rd_q <= 1'b0;
			dos     <= 1'b0;
			dos_n   <= 1'b1;
		end
		else
		begin
			m1_rd_q <= m1_rd;
			dos_n   <= ~dos;
			if (m1_stb)
			begin
				if (bus.a[15:8] == DOS_TRAP_HI && rom_bank[0])
					dos <= 1'b1;
				else if (win != 2'd0)
					dos <= 1'b0;
			end
		end
	end

endmodule

//--- rtl/zports.sv
`timescale 1ns/1ns

module zports #(
	parameter int AY_DIV_LOG2 = 4
) (
	input  logic                          fclk,
	input  logic                          rst_n,
	z80_bus_if.sink                       bus,
	port_state_if.src                     pst,
	output logic [zx_bus_pkg::DATA_W-1:0] dout,
	output logic                          dout_en,
	output logic                          beep,
	output logic                          ay_bdir,
	output logic                          ay_bc1,
	output logic                          ay_clk
);
	import zx_bus_pkg::*;

	logic                   hit_fe;
	logic                   hit_7ffd;
	logic                   hit_eff7;
	logic                   ay_hit;
	logic                   io_wr;
	logic                   io_wr_q;
	logic                   io_rd;
	logic                   wr_stb;
	logic [2:0]             border;
	logic                   beep_r;
	logic [DATA_W-1:0]      p7ffd_r;
	logic [DATA_W-1:0]      peff7_r;
	logic [AY_DIV_LOG2-1:0] ay_div;

	assign hit_fe   = (bus.a & PORT_FE_MASK) == '0;
	assign hit_7ffd = (bus.a & PORT_7FFD_MASK) == '0;
	assign hit_eff7 = bus.a == PORT_EFF7_ADDR;
	assign ay_hit   = (bus.a & PORT_7FFD_MASK) == AY_SEL;

	assign io_wr  = ~bus.iorq_n & ~bus.wr_n;
	assign io_rd  = ~bus.iorq_n & ~bus.rd_n;
	// first sampled edge of a write cycle
	assign wr_stb = io_wr & ~io_wr_q;

	////////////////////////////////////////
	// port registers
	////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_wr_q <= 1'b0;
			border  <= '0;
			beep_r  <= 1'b0;
			p7ffd_r <= '0;
			peff7_r <= '0;
		end
		else
		begin
			io_wr_q <= io_wr;
			if (wr_stb && hit_fe)
			begin
				border <= bus.din[2:0];
				beep_r <= bus.din[4];
			end
			if (wr_stb && hit_7ffd && !pst.lock)
				p7ffd_r <= bus.din;
			if (wr_stb && hit_eff7)
				peff7_r <= bus.din;
		end
	end

	assign pst.p7ffd = p7ffd_r;
	assign pst.peff7 = peff7_r;
	// bit 5 freezes paging until reset
	assign pst.lock  = p7ffd_r[5];
	assign beep      = beep_r;

	always_comb
	begin
		if (hit_eff7)
			dout = peff7_r;
		else if (hit_7ffd)
			dout = p7ffd_r;
		else if (hit_fe)
			dout = {5'b11111, border};
		else
			dout = DATA_IDLE;
	end

	assign dout_en = io_rd;

	////////////////////////////////////////
	// ay chip
	////////////////////////////////////////

	assign ay_bdir = ay_hit & io_wr;
	assign ay_bc1  = ay_hit & (io_rd | io_wr) & bus.a[14];

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			ay_div <= '0;
		else
			ay_div <= ay_div + 1'b1;
	end

	assign ay_clk = ay_div[AY_DIV_LOG2-1];

endmodule

//--- rtl/zx_bus_pkg.sv
package zx_bus_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// hit when the masked address is zero
	localparam logic [ADDR_W-1:0] PORT_FE_MASK   = 16'h0001;
	localparam logic [ADDR_W-1:0] PORT_7FFD_MASK = 16'h8002;

	// full decode
	localparam logic [ADDR_W-1:0] PORT_EFF7_ADDR = 16'hEFF7;

	// under the 7ffd mask, a15 high selects the ay
	localparam logic [ADDR_W-1:0] AY_SEL = 16'h8000;

	// unmapped port readback
	localparam logic [DATA_W-1:0] DATA_IDLE = 8'hFF;

	// int acknowledge cycle
	function automatic logic ack_cycle(input logic iorq_n, input logic m1_n);
		return ~iorq_n & ~m1_n;
	endfunction

endpackage

//--- rtl/zx_core_top.sv
`timescale 1ns/1ns

module zx_core_top #(
	parameter int RST_CNT_SIZE = 6,
	parameter int FRAME_CYCLES = 71680,
	parameter int INT_CYCLES   = 32,
	parameter int AY_DIV_LOG2  = 4
) (
	input  logic                          fclk,
	input  logic                          rst_n,
	input  logic [zx_bus_pkg::ADDR_W-1:0] a,
	inout  wire  [zx_bus_pkg::DATA_W-1:0] d,
	input  logic                          iorq_n,
	input  logic                          mreq_n,
	input  logic                          rd_n,
	input  logic                          wr_n,
	input  logic                          m1_n,
	output logic                          int_n,
	output logic                          res,
	output logic                          beep,
	output logic                          ay_clk,
	output logic                          ay_bdir,
	output logic                          ay_bc1,
	output logic                          csrom,
	output logic                          romoe_n,
	output logic                          rompg0_n,
	output logic                          dos_n,
	output logic                          ram_cs,
	output zx_mem_pkg::ram_page_t         mem_page
);
	import zx_bus_pkg::*;

	logic              rst_core_n;
	logic [DATA_W-1:0] port_dout;
	logic              port_dout_en;

	z80_bus_if    bus ();
	port_state_if pst ();

	// bus pins sampled directly on fclk
	assign bus.a      = a;
	assign bus.din    = d;
	assign bus.iorq_n = iorq_n;
	assign bus.mreq_n = mreq_n;
	assign bus.rd_n   = rd_n;
	assign bus.wr_n   = wr_n;
	assign bus.m1_n   = m1_n;

	assign d   = port_dout_en ? port_dout : 'z;
	assign res = ~rst_core_n;

	////////////////////////////////////////
	// blocks
	////////////////////////////////////////

	reset_stretch #(
		.RST_CNT_SIZE(RST_CNT_SIZE)
	) reset_stretch_i (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.rst_core_n (rst_core_n)
	);

	zports #(
		.AY_DIV_LOG2(AY_DIV_LOG2)
	) zports_i (
		.fclk    (fclk),
		.rst_n   (rst_core_n),
		.bus     (bus),
		.pst     (pst),
		.dout    (port_dout),
		.dout_en (port_dout_en),
		.beep    (beep),
		.ay_bdir (ay_bdir),
		.ay_bc1  (ay_bc1),
		.ay_clk  (ay_clk)
	);

	zmem_map zmem_map_i (
		.fclk     (fclk),
		.rst_n    (rst_core_n),
		.bus      (bus),
		.pst      (pst),
		.csrom    (csrom),
		.romoe_n  (romoe_n),
		.rompg0_n (rompg0_n),
		.dos_n    (dos_n),
		.ram_cs   (ram_cs),
		.mem_page (mem_page)
	);

	zint #(
		.FRAME_CYCLES(FRAME_CYCLES),
		.INT_CYCLES  (INT_CYCLES)
	) zint_i (
		.fclk  (fclk),
		.rst_n (rst_core_n),
		.bus   (bus),
		.int_n (int_n)
	);

endmodule

//--- rtl/zx_mem_pkg.sv
package zx_mem_pkg;

	// a[15:14]
	typedef logic [1:0] win_idx_t;

	typedef logic [7:0] ram_page_t;

	// bit 0 selects 48k rom, bit 1 is dos
	typedef logic [1:0] rom_bank_t;

	// one page byte per window
	typedef union packed
	{
		ram_page_t ram;
		struct packed
		{
			logic [5:0] pad;
			rom_bank_t  bank;
		} rom;
	} page_word_u;

	// fixed pages of the middle windows
	localparam ram_page_t RAM_PAGE_WIN1 = 8'd5;
	localparam ram_page_t RAM_PAGE_WIN2 = 8'd2;

	// m1 fetch from #3Dxx enters dos
	localparam logic [7:0] DOS_TRAP_HI = 8'h3D;

endpackage

//--- test/tb_zx_core.sv
`timescale 1ns/1ns

module tb_zx_core;

	localparam int FRAME_CYCLES = 200;
	localparam int INT_CYCLES   = 32;
	localparam int AY_DIV_LOG2  = 4;
	localparam int WAIT_LIMIT   = 1000;

	logic        fclk;
	logic        rst_n;
	logic [15:0] a;
	wire  [7:0]  d;
	logic [7:0]  d_drv;
	logic        d_oe;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic        int_n;
	logic        res;
	logic        beep;
	logic        ay_clk;
	logic        ay_bdir;
	logic        ay_bc1;
	logic        csrom;
	logic        romoe_n;
	logic        rompg0_n;
	logic        dos_n;
	logic        ram_cs;
	logic [7:0]  mem_page;

	// taken in the middle of the last bus cycle
	logic [7:0]  rd_data;
	logic [7:0]  seen_page;
	logic        seen_bdir;
	logic        seen_bc1;
	logic        seen_csrom;
	logic        seen_romoe_n;
	logic        seen_ram_cs;
	logic        seen_int_n;

	assign d = d_oe ? d_drv : 'z;

	zx_core_top #(
		.FRAME_CYCLES(FRAME_CYCLES),
		.INT_CYCLES  (INT_CYCLES),
		.AY_DIV_LOG2 (AY_DIV_LOG2)
	) zx_core_top_i (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.a        (a),
		.d        (d),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.int_n    (int_n),
		.res      (res),
		.beep     (beep),
		.ay_clk   (ay_clk),
		.ay_bdir  (ay_bdir),
		.ay_bc1   (ay_bc1),
		.csrom    (csrom),
		.romoe_n  (romoe_n),
		.rompg0_n (rompg0_n),
		.dos_n    (dos_n),
		.ram_cs   (ram_cs),
		.mem_page (mem_page)
	);

	initial
	begin
		fclk = 1'b0;
		forever
			#2 fclk = ~fclk;
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
			abort_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
	endtask

	// strobes {iorq_n, mreq_n, rd_n, wr_n, m1_n} held for one cycle
	task automatic bus_cycle(input logic [15:0] addr, input logic [4:0] strobes_n,
		input logic [7:0] wdata);
		@(posedge fclk);
		#1;
		a     = addr;
		d_drv = wdata;
		d_oe  = ~strobes_n[1];
		{iorq_n, mreq_n, rd_n, wr_n, m1_n} = strobes_n;
		@(negedge fclk);
		rd_data      = d;
		seen_page    = mem_page;
		seen_bdir    = ay_bdir;
		seen_bc1     = ay_bc1;
		seen_csrom   = csrom;
		seen_romoe_n = romoe_n;
		seen_ram_cs  = ram_cs;
		seen_int_n   = int_n;
		@(posedge fclk);
		#1;
		{iorq_n, mreq_n, rd_n, wr_n, m1_n} = 5'b11111;
		d_oe = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		bus_cycle(addr, 5'b01101, data);
	endtask

	task automatic io_read(input logic [15:0] addr);
		bus_cycle(addr, 5'b01011, 8'h00);
	endtask

	task automatic mem_read(input logic [15:0] addr);
		bus_cycle(addr, 5'b10011, 8'h00);
	endtask

	task automatic m1_fetch(input logic [15:0] addr);
		bus_cycle(addr, 5'b10010, 8'h00);
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (res !== 1'b0)
		begin
			@(negedge fclk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("Timeout: the core reset was never released");
		end
	endtask

	// counts cycles until int_n is seen at the given level
	task automatic count_to_int_level(input logic level, output int cycles);
		cycles = 0;
		do
		begin
			@(negedge fclk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("Timeout: int_n did not change level");
		end
		while (int_n !== level);
	endtask

	// counts cycles until ay_clk is seen at the given level
	task automatic count_to_ay_level(input logic level, output int cycles);
		cycles = 0;
		do
		begin
			@(negedge fclk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				abort_run("Timeout: ay_clk did not change level");
		end
		while (ay_clk !== level);
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic reset_state();
		wait_reset_release();
		check("int_n", 16'(int_n), 16'h1);
		check("beep", 16'(beep), 16'h0);
		mem_read(16'h0000);
		check("csrom", 16'(seen_csrom), 16'h1);
		check("romoe_n", 16'(seen_romoe_n), 16'h0);
		check("rompg0_n", 16'(rompg0_n), 16'h1);
		check("dos_n", 16'(dos_n), 16'h1);
		io_read(16'h7FFD);
		check("d", 16'(rd_data), 16'h0000);
	endtask

	task automatic port_access();
		logic [7:0] val;
		int         i;
		for (i = 0; i < 8; i++)
		begin
			val = 8'($urandom);
			io_write(16'h00FE, val);
			check("beep", 16'(beep), 16'(val[4]));
			io_read(16'h00FE);
			check("d", 16'(rd_data), 16'({5'b11111, val[2:0]}));
		end
		val = 8'($urandom);
		io_write(16'hEFF7, val);
		io_read(16'hEFF7);
		check("d", 16'(rd_data), 16'(val));
		io_read(16'h00FF);
		check("d", 16'(rd_data), 16'h00FF);
		io_write(16'hFFFD, 8'($urandom));
		check("ay_bdir", 16'(seen_bdir), 16'h1);
		check("ay_bc1", 16'(seen_bc1), 16'h1);
	endtask

	task automatic ay_clock();
		int low_len;
		int high_len;
		count_to_ay_level(1'b0, low_len);
		count_to_ay_level(1'b1, low_len);
		count_to_ay_level(1'b0, high_len);
		count_to_ay_level(1'b1, low_len);
		check("ay_clk period", 16'(low_len + high_len), 16'(1 << AY_DIV_LOG2));
	endtask

	task automatic paging();
		logic [7:0] val;
		logic [7:0] locked;
		int         i;
		for (i = 0; i < 6; i++)
		begin
			val = 8'($urandom) & 8'hDF;
			io_write(16'h7FFD, val);
			io_read(16'h7FFD);
			check("d", 16'(rd_data), 16'(val));
			mem_read({2'b11, 14'($urandom)});
			check("ram_cs", 16'(seen_ram_cs), 16'h1);
			check("mem_page", 16'(seen_page), 16'(val[2:0]));
			mem_read({2'b01, 14'($urandom)});
			check("mem_page", 16'(seen_page), 16'h5);
			mem_read({2'b10, 14'($urandom)});
			check("mem_page", 16'(seen_page), 16'h2);
			check("rompg0_n", 16'(rompg0_n), 16'(!val[4]));
		end
		// lock with the 48k rom selected
		locked = 8'h30 | 8'($urandom % 8);
		io_write(16'h7FFD, locked);
		io_write(16'h7FFD, ~locked);
		io_read(16'h7FFD);
		check("d", 16'(rd_data), 16'(locked));
	endtask

	task automatic ram_window0();
		io_write(16'hEFF7, 8'h04);
		mem_read(16'h0000);
		check("ram_cs", 16'(seen_ram_cs), 16'h1);
		check("mem_page", 16'(seen_page), 16'h0);
		check("csrom", 16'(seen_csrom), 16'h0);
	endtask

	task automatic dos_latch();
		io_write(16'hEFF7, 8'h00);
		m1_fetch(16'h3D00);
		repeat (2) @(negedge fclk);
		check("dos_n", 16'(dos_n), 16'h0);
		m1_fetch(16'h8000);
		repeat (2) @(negedge fclk);
		check("dos_n", 16'(dos_n), 16'h1);
	endtask

	task automatic frame_interrupt();
		int low_len;
		int high_len;
		count_to_int_level(1'b1, high_len);
		count_to_int_level(1'b0, high_len);
		count_to_int_level(1'b1, low_len);
		count_to_int_level(1'b0, high_len);
		check("int_n low cycles", 16'(low_len), 16'(INT_CYCLES));
		check("int_n period", 16'(low_len + high_len), 16'(FRAME_CYCLES));
		// acknowledge early in the pulse
		bus_cycle(16'h0000, 5'b01110, 8'h00);
		check("int_n", 16'(seen_int_n), 16'h0);
		check("int_n", 16'(int_n), 16'h1);
	endtask

	initial
	begin
		void'($urandom(96473));
		rst_n  = 1'b0;
		a      = '0;
		d_drv  = '0;
		d_oe   = 1'b0;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		repeat (16) @(posedge fclk);
		#1;
		rst_n = 1'b1;
		reset_state();
		port_access();
		ay_clock();
		paging();
		ram_window0();
		dos_latch();
		frame_interrupt();
		if (zx_core_top_i.zx_core_props_i.fail_cnt == 0)
		begin
			$display("Testbench passed");
			$finish;
		end
		else
		begin
			abort_run("Assertion failures in the bound checker");
		end
	end

endmodule

//--- test/zx_core_props.sv
`timescale 1ns/1ns

module zx_core_props #(
	parameter int INT_CYCLES = 32
) (
	input logic fclk,
	input logic rst_n,
	input logic res,
	input logic iorq_n,
	input logic wr_n,
	input logic int_n,
	input logic ay_bdir,
	input logic csrom,
	input logic romoe_n,
	input logic ram_cs
);

	int low_cnt;
	int fail_cnt = 0;

	// length of the current int pulse
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			low_cnt <= 0;
		else if (!int_n)
			low_cnt <= low_cnt + 1;
		else
			low_cnt <= 0;
	end

	rom_oe_in_rom: assert property (@(posedge fclk) disable iff (res) !romoe_n |-> csrom)
	else
	begin
		fail_cnt++;
		$error("romoe_n low without csrom");
	end

	rom_ram_apart: assert property (@(posedge fclk) disable iff (res) !(csrom && ram_cs))
	else
	begin
		fail_cnt++;
		$error("csrom and ram_cs high together");
	end

	int_pulse_len: assert property (@(posedge fclk) disable iff (res) low_cnt <= INT_CYCLES)
	else
	begin
		fail_cnt++;
		$error("int_n low for more than %0d cycles", INT_CYCLES);
	end

	ay_write_only: assert property (@(posedge fclk) disable iff (res)
		ay_bdir |-> (!iorq_n && !wr_n))
	else
	begin
		fail_cnt++;
		$error("ay_bdir high outside an i/o write");
	end

endmodule

bind zx_core_top zx_core_props #(
	.INT_CYCLES(INT_CYCLES)
) zx_core_props_i (
	.fclk    (fclk),
	.rst_n   (rst_n),
	.res     (res),
	.iorq_n  (iorq_n),
	.wr_n    (wr_n),
	.int_n   (int_n),
	.ay_bdir (ay_bdir),
	.csrom   (csrom),
	.romoe_n (romoe_n),
	.ram_cs  (ram_cs)
);
